//--- sim.f
+incdir+testbench
design/corr_pkg.sv
design/pair_sequencer.sv
design/mac_cos_sin.sv
design/visibility_banks.sv
design/bus_read_port.sv
design/correlator_top.sv
testbench/tb_correlator.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/10ps
LINTFLAGS := --lint-only -Wall --timescale 1ns/10ps
TOP       := tb_correlator
RTL_TOP   := correlator_top
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation finished: PASS

SOURCES   := $(shell grep -v '^+' $(FILELIST))
RTL_FILES := $(filter design/%,$(SOURCES))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST) testbench/tb_model.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_model.svh
// ---------------------------------------------------------------------------
// Stimulus table
// ---------------------------------------------------------------------------
typedef struct packed {
   int                count;
   logic              rnd;
   corr_pkg::sample_t pattern;
   int                sw_at;
   logic              readback;
   logic              wr_probe;
} stim_row_t;

localparam int STIM_ROWS = 6;

// Sample count, random or fixed pattern, sw_i on sample sw_at, bus checks after the row
localparam stim_row_t STIM_TABLE [STIM_ROWS] = '{
   // Three frames with idle gaps, swap asked for in the last frame
   '{count: 36, rnd: 1'b1, pattern: '0, sw_at: 30, readback: 1'b1, wr_probe: 1'b0},
   // Second period into the other bank
   '{count: 48, rnd: 1'b1, pattern: '0, sw_at: 40, readback: 1'b1, wr_probe: 1'b0},
   // Old bank comes back, sw_i on the wrap sample itself
   '{count: 24, rnd: 1'b1, pattern: '0, sw_at: 23, readback: 1'b1, wr_probe: 1'b0},
   // No samples, bus write then read again
   '{count: 0, rnd: 1'b0, pattern: '0, sw_at: -1, readback: 1'b1, wr_probe: 1'b1},
   // 260 frames of zeros drive every counter into saturation
   '{count: 3120, rnd: 1'b0, pattern: '0, sw_at: 3114, readback: 1'b1, wr_probe: 1'b0},
   // Swap asked for mid-frame
   '{count: 24, rnd: 1'b1, pattern: '0, sw_at: 5, readback: 1'b1, wr_probe: 1'b0}
};

// ---------------------------------------------------------------------------
// Reference model
// ---------------------------------------------------------------------------
localparam corr_pkg::acc_t ACC_MAX = '1;

// Counts per bank and pair slot
corr_pkg::acc_t      model_cos [2][16];
corr_pkg::acc_t      model_sin [2][16];
corr_pkg::pair_adr_t model_adr;
logic                model_bank;
logic                model_clear;
logic                model_pending;
logic                model_ovf_cos;
logic                model_ovf_sin;
int                  error_count;

task automatic model_reset();
   model_adr     = '0;
   model_bank    = 1'b0;
   // First frame after reset starts from zero
   model_clear   = 1'b1;
   model_pending = 1'b0;
   model_ovf_cos = 1'b0;
   model_ovf_sin = 1'b0;
endtask

// One clock cycle of inputs
task automatic model_cycle(input logic en, input corr_pkg::sample_t s, input logic sw);
   corr_pkg::pair_t p;
   corr_pkg::acc_t  c;
   corr_pkg::acc_t  n;
   if (sw) begin
      model_pending = 1'b1;
   end
   if (en) begin
      p = corr_pkg::PAIR_TABLE[model_adr];
      c = model_clear ? '0 : model_cos[model_bank][model_adr];
      n = model_clear ? '0 : model_sin[model_bank][model_adr];
      // Equal signs add one, a full counter holds and raises its flag
      if (s.re[p.a] == s.re[p.b]) begin
         if (c == ACC_MAX) begin
            model_ovf_cos = 1'b1;
         end else begin
            c = c + 1'b1;
         end
      end
      if (s.re[p.a] == s.im[p.b]) begin
         if (n == ACC_MAX) begin
            model_ovf_sin = 1'b1;
         end else begin
            n = n + 1'b1;
         end
      end
      model_cos[model_bank][model_adr] = c;
      model_sin[model_bank][model_adr] = n;
      // Swap only at the end of a frame
      if (model_adr == corr_pkg::LAST_PAIR) begin
         model_adr   = '0;
         model_clear = model_pending;
         if (model_pending) begin
            model_bank = ~model_bank;
         end
         model_pending = 1'b0;
      end else begin
         model_adr = model_adr + 1'b1;
      end
   end
endtask

// Bus view of the inactive bank, unused pair slots read zero
function automatic corr_pkg::acc_t expected_word(input corr_pkg::bus_adr_t adr);
   logic b;
   b = ~model_bank;
   if (adr[3:0] > corr_pkg::LAST_PAIR) begin
      return '0;
   end
   return adr[4] ? model_sin[b][adr[3:0]] : model_cos[b][adr[3:0]];
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
   if (expected !== actual) begin
      error_count++;
      $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, expected, actual);
   end
endtask

//--- testbench/tb_correlator.sv
`timescale 1ns/10ps

module tb_correlator;

   logic                clk_x = 1'b0;
   logic                rst;
   logic                en_i;
   corr_pkg::sample_t   sample_i;
   logic                sw_i;
   corr_pkg::bus_req_t  bus_i;
   logic                ack_o;
   corr_pkg::acc_t      dat_o;
   logic                bank_o;
   logic                overflow_cos_o;
   logic                overflow_sin_o;

   // Cycles allowed for ack_o
   localparam int ACK_TIMEOUT = 16;
   // All cos and sin slots of one bank
   localparam int BUS_WORDS = 2 ** $bits(corr_pkg::bus_adr_t);

   `include "tb_model.svh"

   correlator_top DUT (
      .clk_x          (clk_x),
      .rst            (rst),
      .en_i           (en_i),
      .sample_i       (sample_i),
      .sw_i           (sw_i),
      .bus_i          (bus_i),
      .ack_o          (ack_o),
      .dat_o          (dat_o),
      .bank_o         (bank_o),
      .overflow_cos_o (overflow_cos_o),
      .overflow_sin_o (overflow_sin_o)
   );

   // 10 ns clock
   always #5 clk_x = ~clk_x;

   // ------------------------------------------------------------------------
   // Stimulus helpers
   // ------------------------------------------------------------------------
   function automatic corr_pkg::sample_t random_sample();
      logic [31:0]       re_bits;
      logic [31:0]       im_bits;
      corr_pkg::sample_t s;
      re_bits = $urandom;
      im_bits = $urandom;
      s.re    = re_bits[corr_pkg::ANTENNAS-1:0];
      s.im    = im_bits[corr_pkg::ANTENNAS-1:0];
      return s;
   endfunction

   // Bank must match the model before each new input
   task automatic drive_cycle(input logic en, input corr_pkg::sample_t s, input logic sw);
      @(posedge clk_x);
      #1;
      check_value("bank_o", 32'(model_bank), 32'(bank_o));
      en_i     = en;
      sample_i = s;
      sw_i     = sw;
      model_cycle(en, s, sw);
   endtask

   // One bus request, held until ack_o or timeout
   task automatic bus_access(input logic we, input corr_pkg::bus_adr_t adr,
                             output corr_pkg::acc_t data, output logic ok);
      int waited;
      @(posedge clk_x);
      #1;
      bus_i  = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr};
      ok     = 1'b0;
      waited = 0;
      while (!ok && waited < ACK_TIMEOUT) begin
         @(posedge clk_x);
         #1;
         if (ack_o) begin
            ok = 1'b1;
         end else begin
            waited++;
         end
      end
      bus_i = '0;
      data  = dat_o;
      if (!ok) begin
         error_count++;
         $display("Timeout: no ack_o for bus address %0h", adr);
      end
   endtask

   task automatic read_inactive_bank();
      corr_pkg::bus_adr_t adr;
      corr_pkg::acc_t     data;
      logic               ok;
      int                 i;
      for (i = 0; i < BUS_WORDS; i++) begin
         adr = corr_pkg::bus_adr_t'(i);
         bus_access(1'b0, adr, data, ok);
         if (ok) begin
            check_value($sformatf("%s[%0d]", adr[4] ? "sin" : "cos", adr[3:0]),
                        32'(expected_word(adr)), 32'(data));
         end
      end
      check_value("overflow_cos_o", 32'(model_ovf_cos), 32'(overflow_cos_o));
      check_value("overflow_sin_o", 32'(model_ovf_sin), 32'(overflow_sin_o));
   endtask

   // ------------------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------------------
   initial begin
      corr_pkg::sample_t s;
      corr_pkg::acc_t    data;
      logic              ok;
      int                r;
      int                k;
      int                seed_val;
      seed_val    = $urandom(32'hb828d99d);
      error_count = 0;
      rst         = 1'b1;
      en_i        = 1'b0;
      sample_i    = '0;
      sw_i        = 1'b0;
      bus_i       = '0;
      repeat (8) @(posedge clk_x);
      #1;
      rst = 1'b0;
      // Quiet outputs straight out of reset
      check_value("ack_o", 32'd0, 32'(ack_o));
      check_value("overflow_cos_o", 32'd0, 32'(overflow_cos_o));
      check_value("overflow_sin_o", 32'd0, 32'(overflow_sin_o));
      check_value("bank_o", 32'd0, 32'(bank_o));
      model_reset();

      for (r = 0; r < STIM_ROWS; r++) begin
         for (k = 0; k < STIM_TABLE[r].count; k++) begin
            s = STIM_TABLE[r].pattern;
            if (STIM_TABLE[r].rnd) begin
               // Occasional idle cycle between strobes
               if ($urandom_range(3) == 0) begin
                  drive_cycle(1'b0, '0, 1'b0);
               end
               s = random_sample();
            end
            drive_cycle(1'b1, s, k == STIM_TABLE[r].sw_at);
         end
         if (STIM_TABLE[r].readback) begin
            // Let the last write-back land
            repeat (6) drive_cycle(1'b0, '0, 1'b0);
            read_inactive_bank();
            if (STIM_TABLE[r].wr_probe) begin
               bus_access(1'b1, 5'h13, data, ok);
               read_inactive_bank();
            end
         end
      end

      $display("Checks complete with %0d errors", error_count);
      if (error_count == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

//--- design/correlator_top.sv
`timescale 1ns/10ps

module correlator_top (
   input  logic                clk_x,
   input  logic                rst,
   input  logic                en_i,
   input  corr_pkg::sample_t   sample_i,
   input  logic                sw_i,
   input  corr_pkg::bus_req_t  bus_i,
   output logic                ack_o,
   output corr_pkg::acc_t      dat_o,
   output logic                bank_o,
   output logic                overflow_cos_o,
   output logic                overflow_sin_o
);

   // Sequencer to MAC and memory
   corr_pkg::lag_t      lag;
   logic                go;
   corr_pkg::bus_adr_t  rd_adr;
   logic                rd_en;
   logic                clear;
   logic                bank;

   // Memory and MAC loop
   corr_pkg::acc_pair_t rd_data;
   corr_pkg::acc_pair_t wr_data;
   corr_pkg::bus_adr_t  wr_adr;
   logic                valid;

   // Bus side of the memory
   corr_pkg::bus_adr_t  mem_adr;
   logic                mem_sel;
   corr_pkg::acc_t      mem_data;

   // ------------------------------------------------------------------------
   // Producer, read and lookup in the strobe cycle
   // ------------------------------------------------------------------------
   pair_sequencer u_seq (
      .clk_x    (clk_x),
      .rst      (rst),
      .en_i     (en_i),
      .sample_i (sample_i),
      .sw_i     (sw_i),
      .lag_o    (lag),
      .go_o     (go),
      .rd_adr_o (rd_adr),
      .rd_en_o  (rd_en),
      .clear_o  (clear),
      .bank_o   (bank)
   );

   // One cycle later the MAC adds
   mac_cos_sin u_mac (
      .clk_x          (clk_x),
      .rst            (rst),
      .go_i           (go),
      .lag_i          (lag),
      .acc_i          (rd_data),
      .valid_o        (valid),
      .wr_adr_o       (wr_adr),
      .acc_o          (wr_data),
      .overflow_cos_o (overflow_cos_o),
      .overflow_sin_o (overflow_sin_o)
   );

   // Two banks, both ports
   visibility_banks u_mem (
      .clk_x      (clk_x),
      .rst        (rst),
      .rd_en_i    (rd_en),
      .rd_adr_i   (rd_adr),
      .clear_i    (clear),
      .rd_data_o  (rd_data),
      .wr_en_i    (valid),
      .wr_adr_i   (wr_adr),
      .wr_data_i  (wr_data),
      .bus_adr_i  (mem_adr),
      .bus_sel_i  (mem_sel),
      .bus_data_o (mem_data)
   );

   // Consumer on the inactive bank
   bus_read_port u_bus (
      .clk_x      (clk_x),
      .rst        (rst),
      .bus_i      (bus_i),
      .bank_i     (bank),
      .mem_adr_o  (mem_adr),
      .mem_sel_o  (mem_sel),
      .mem_data_i (mem_data),
      .ack_o      (ack_o),
      .dat_o      (dat_o)
   );

   assign bank_o = bank;

endmodule

//--- design/bus_read_port.sv
`timescale 1ns/10ps

module bus_read_port (
   input  logic                 clk_x,
   input  logic                 rst,
   input  corr_pkg::bus_req_t   bus_i,
   input  logic                 bank_i,
   output corr_pkg::bus_adr_t   mem_adr_o,
   output logic                 mem_sel_o,
   input  corr_pkg::acc_t       mem_data_i,
   output logic                 ack_o,
   output corr_pkg::acc_t       dat_o
);

   logic           strobe;
   logic           ack_q;
   corr_pkg::acc_t dat_q;

   assign strobe = bus_i.cyc && bus_i.stb;

   // Always the bank that the MAC is not updating
   assign mem_adr_o = {~bank_i, bus_i.adr[3:0]};
   // cos or sin
   assign mem_sel_o = bus_i.adr[4];

   // Every request gets an ack, writes included
   always_ff @(posedge clk_x) begin
      if (rst) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= strobe;
      end
   end

   // Read data only for reads, a write leaves dat_o as it was
   always_ff @(posedge clk_x) begin
      if (strobe && !bus_i.we) begin
         dat_q <= mem_data_i;
      end
   end

   assign ack_o = ack_q;
   assign dat_o = dat_q;

endmodule

//--- design/visibility_banks.sv
`timescale 1ns/10ps

module visibility_banks (
   input  logic                 clk_x,
   input  logic                 rst,
   // Accumulator read, one cycle before go
   input  logic                 rd_en_i,
   input  corr_pkg::bus_adr_t   rd_adr_i,
   input  logic                 clear_i,
   output corr_pkg::acc_pair_t  rd_data_o,
   // Write-back from the MAC
   input  logic                 wr_en_i,
   input  corr_pkg::bus_adr_t   wr_adr_i,
   input  corr_pkg::acc_pair_t  wr_data_i,
   // Bus side, combinational
   input  corr_pkg::bus_adr_t   bus_adr_i,
   input  logic                 bus_sel_i,
   output corr_pkg::acc_t       bus_data_o
);

   // ------------------------------------------------------------------------
   // Storage
   // ------------------------------------------------------------------------
   // Word index is {bank, pair}, slots 12 to 15 of each bank are never written
   corr_pkg::acc_t cos_mem [corr_pkg::MEM_WORDS];
   corr_pkg::acc_t sin_mem [corr_pkg::MEM_WORDS];

   corr_pkg::acc_pair_t rd_data_q;
   corr_pkg::acc_t      bus_word;

   // ------------------------------------------------------------------------
   // Accumulator read and write
   // ------------------------------------------------------------------------
   // Old value for the MAC, zero while the bank is in its first frame
   always_ff @(posedge clk_x) begin
      if (rd_en_i) begin
         if (clear_i) begin
            rd_data_q <= '0;
         end else begin
            rd_data_q.cos <= cos_mem[rd_adr_i];
            rd_data_q.sin <= sin_mem[rd_adr_i];
         end
      end
   end

   assign rd_data_o = rd_data_q;

   // Write-back two edges after the read of the same word
   always_ff @(posedge clk_x) begin
      if (wr_en_i) begin
         cos_mem[wr_adr_i] <= wr_data_i.cos;
         sin_mem[wr_adr_i] <= wr_data_i.sin;
      end
   end

   // ------------------------------------------------------------------------
   // Bus read
   // ------------------------------------------------------------------------
   // Quadrature select from the bus address top bit
   assign bus_word = bus_sel_i ? sin_mem[bus_adr_i] : cos_mem[bus_adr_i];

   // Unused pair slots read as zero
   assign bus_data_o = (bus_adr_i[3:0] > corr_pkg::LAST_PAIR) ? '0 : bus_word;

   // Only table addresses get written
   assert property (@(posedge clk_x) disable iff (rst)
      wr_en_i |-> wr_adr_i[3:0] <= corr_pkg::LAST_PAIR);

   // Every read comes back as a write to the same word through the MAC
   assert property (@(posedge clk_x) disable iff (rst)
      rd_en_i |-> ##2 (wr_en_i && wr_adr_i == $past(rd_adr_i, 2)));

endmodule

//--- design/mac_cos_sin.sv
`timescale 1ns/10ps

module mac_cos_sin (
   input  logic                 clk_x,
   input  logic                 rst,
   input  logic                 go_i,
   input  corr_pkg::lag_t       lag_i,
   input  corr_pkg::acc_pair_t  acc_i,
   output logic                 valid_o,
   output corr_pkg::bus_adr_t   wr_adr_o,
   output corr_pkg::acc_pair_t  acc_o,
   output logic                 overflow_cos_o,
   output logic                 overflow_sin_o
);

   corr_pkg::acc_pair_t base;
   corr_pkg::acc_pair_t acc_q;
   corr_pkg::bus_adr_t  wr_adr_q;
   logic                cos_hit;
   logic                sin_hit;
   logic                cos_full;
   logic                sin_full;
   logic                valid_q;
   logic                ovf_cos_q;
   logic                ovf_sin_q;

   // Start from zero in the first frame after a swap
   assign base = lag_i.clear ? '0 : acc_i;

   // One-bit multiply, equal signs give +1
   assign cos_hit = ~(lag_i.ar ^ lag_i.br);
   assign sin_hit = ~(lag_i.ar ^ lag_i.bi);

   // Counter already at its top value
   assign cos_full = &base.cos;
   assign sin_full = &base.sin;

   // Saturating accumulate
   always_ff @(posedge clk_x) begin
      if (go_i) begin
         acc_q.cos <= (cos_hit && !cos_full) ? base.cos + 1'b1 : base.cos;
         acc_q.sin <= (sin_hit && !sin_full) ? base.sin + 1'b1 : base.sin;
         wr_adr_q  <= lag_i.adr;
      end
   end

   // Write strobe and sticky flags, set only by a blocked increment
   always_ff @(posedge clk_x) begin
      if (rst) begin
         valid_q   <= 1'b0;
         ovf_cos_q <= 1'b0;
         ovf_sin_q <= 1'b0;
      end else begin
         valid_q <= go_i;
         if (go_i && cos_hit && cos_full) begin
            ovf_cos_q <= 1'b1;
         end
         if (go_i && sin_hit && sin_full) begin
            ovf_sin_q <= 1'b1;
         end
      end
   end

   assign valid_o        = valid_q;
   assign wr_adr_o       = wr_adr_q;
   assign acc_o          = acc_q;
   assign overflow_cos_o = ovf_cos_q;
   assign overflow_sin_o = ovf_sin_q;

endmodule

//--- design/pair_sequencer.sv
`timescale 1ns/10ps

module pair_sequencer (
   input  logic                clk_x,
   input  logic                rst,
   input  logic                en_i,
   input  corr_pkg::sample_t   sample_i,
   input  logic                sw_i,
   output corr_pkg::lag_t      lag_o,
   output logic                go_o,
   output corr_pkg::bus_adr_t  rd_adr_o,
   output logic                rd_en_o,
   output logic                clear_o,
   output logic                bank_o
);

   corr_pkg::seq_state_t state_q;
   corr_pkg::pair_adr_t  pair_adr_q;
   corr_pkg::pair_t      pair_sel;
   corr_pkg::lag_t       lag_q;
   logic                 bank_q;
   // Swap request seen while the current bank is still clearing
   logic                 late_sw_q;
   logic                 go_q;
   logic                 wrap;

   // Antenna pair for the current address
   assign pair_sel = corr_pkg::PAIR_TABLE[pair_adr_q];
   // Accepted sample at the last table entry
   assign wrap     = en_i && (pair_adr_q == corr_pkg::LAST_PAIR);

   // Memory read happens in the same cycle as the strobe
   assign rd_adr_o = {bank_q, pair_adr_q};
   assign rd_en_o  = en_i;
   assign clear_o  = (state_q == corr_pkg::CLEARING);

   assign lag_o  = lag_q;
   assign go_o   = go_q;
   assign bank_o = bank_q;

   // ------------------------------------------------------------------------
   // Address counter, one step per accepted sample
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         pair_adr_q <= '0;
         go_q       <= 1'b0;
      end else begin
         go_q <= en_i;
         if (wrap) begin
            pair_adr_q <= '0;
         end else if (en_i) begin
            pair_adr_q <= pair_adr_q + 1'b1;
         end
      end
   end

   // Sign bits and target word ride along with go
   always_ff @(posedge clk_x) begin
      if (en_i) begin
         lag_q.ar    <= sample_i.re[pair_sel.a];
         lag_q.br    <= sample_i.re[pair_sel.b];
         lag_q.bi    <= sample_i.im[pair_sel.b];
         lag_q.adr   <= rd_adr_o;
         lag_q.clear <= clear_o;
      end
   end

   // ------------------------------------------------------------------------
   // Bank control
   // ------------------------------------------------------------------------
   // Sample 11 still lands in the old bank, the flip takes effect after it
   always_ff @(posedge clk_x) begin
      if (rst) begin
         state_q   <= corr_pkg::CLEARING;
         bank_q    <= 1'b0;
         late_sw_q <= 1'b0;
      end else begin
         case (state_q)
            corr_pkg::RUN: begin
               if (wrap && sw_i) begin
                  bank_q  <= ~bank_q;
                  state_q <= corr_pkg::CLEARING;
               end else if (sw_i) begin
                  state_q <= corr_pkg::PENDING_SWAP;
               end
            end
            corr_pkg::PENDING_SWAP: begin
               if (wrap) begin
                  bank_q  <= ~bank_q;
                  state_q <= corr_pkg::CLEARING;
               end
            end
            corr_pkg::CLEARING: begin
               if (wrap) begin
                  late_sw_q <= 1'b0;
                  // Back-to-back swap, next bank also starts from zero
                  if (late_sw_q || sw_i) begin
                     bank_q <= ~bank_q;
                  end else begin
                     state_q <= corr_pkg::RUN;
                  end
               end else if (sw_i) begin
                  late_sw_q <= 1'b1;
               end
            end
            default: state_q <= corr_pkg::CLEARING;
         endcase
      end
   end

   // go follows every accepted strobe by exactly one cycle
   assert property (@(posedge clk_x) disable iff (rst)
      go_o == $past(en_i));

endmodule

//--- design/corr_pkg.sv
package corr_pkg;

   // ------------------------------------------------------------------------
   // Sizes
   // ------------------------------------------------------------------------
   // Sign-bit inputs, one real and one imaginary per antenna
   localparam int ANTENNAS = 24;
   // Pair table length, also the number of samples in one frame
   localparam int PAIRS = 12;
   // Small on purpose so that saturation shows up in simulation
   localparam int ACC_W = 8;

   // Index of one antenna within the sign-bit vectors
   typedef logic [4:0] ant_idx_t;
   // Position within the pair table
   typedef logic [3:0] pair_adr_t;
   // One cos or sin counter
   typedef logic [ACC_W-1:0] acc_t;
   // Bit 4 picks sin (1) or cos (0) on the bus, and the memory bank internally
   typedef logic [4:0] bus_adr_t;

   // Last table entry, where the address wraps
   localparam pair_adr_t LAST_PAIR = pair_adr_t'(PAIRS - 1);
   // Both banks of sixteen pair slots in one array
   localparam int MEM_WORDS = 2 ** $bits(bus_adr_t);

   // ------------------------------------------------------------------------
   // Pair table
   // ------------------------------------------------------------------------
   typedef struct packed {
      ant_idx_t a;
      ant_idx_t b;
   } pair_t;

   // Short baselines first, then longer ones across the array
   localparam pair_t PAIR_TABLE [PAIRS] = '{
      '{a: 5'd0,  b: 5'd1},
      '{a: 5'd0,  b: 5'd2},
      '{a: 5'd1,  b: 5'd2},
      '{a: 5'd3,  b: 5'd7},
      '{a: 5'd4,  b: 5'd9},
      '{a: 5'd5,  b: 5'd11},
      '{a: 5'd6,  b: 5'd13},
      '{a: 5'd8,  b: 5'd15},
      '{a: 5'd10, b: 5'd17},
      '{a: 5'd12, b: 5'd19},
      '{a: 5'd14, b: 5'd21},
      '{a: 5'd16, b: 5'd23}
   };

   // ------------------------------------------------------------------------
   // Structs
   // ------------------------------------------------------------------------
   // One sign bit per antenna, for both quadratures
   typedef struct packed {
      logic [ANTENNAS-1:0] re;
      logic [ANTENNAS-1:0] im;
   } sample_t;

   // Sequencer to MAC
   typedef struct packed {
      logic     ar;
      logic     br;
      logic     bi;
      // Bank bit and pair address of the memory word to update
      bus_adr_t adr;
      // First frame after a swap starts from zero
      logic     clear;
   } lag_t;

   // Memory word, read and write
   typedef struct packed {
      acc_t cos;
      acc_t sin;
   } acc_pair_t;

   // Bus request, writes carry no data
   typedef struct packed {
      logic     cyc;
      logic     stb;
      logic     we;
      bus_adr_t adr;
   } bus_req_t;

   // Bank control states
   typedef enum logic [1:0] {
      RUN,
      PENDING_SWAP,
      CLEARING
   } seq_state_t;

endpackage
